//--- rtl/uart_pkg.sv
package uart_pkg;

  typedef logic [7:0] byte_t;  // one data byte on the wire

  // received word as it travels through the receive FIFO
  typedef struct packed {
    byte_t data;  // deserialized payload, lsb arrived first
    logic  ferr;  // stop bit was sampled low
  } rx_word_t;

  localparam int EXTRA_STOP_BITS = 7;  // idle bits after the real stop bit
  localparam int FRAME_BITS = 1 + 8 + 1 + EXTRA_STOP_BITS;  // start, data, stop, extra stops

  localparam logic [1:0] REG_CTRL   = 2'd0;  // tx enable and loopback
  localparam logic [1:0] REG_STATUS = 2'd1;  // idle, overrun and empty flags
  localparam logic [1:0] REG_FERR   = 2'd2;  // saturating frame error count

  localparam int CTRL_TX_EN_BIT = 0;  // lets the transmitter drain its FIFO
  localparam int CTRL_LOOP_BIT  = 1;  // feeds the tx line back into the receiver

  localparam int STAT_TX_IDLE_BIT  = 0;  // serializer has finished all stop bits
  localparam int STAT_OVERRUN_BIT  = 1;  // sticky, a received word was dropped
  localparam int STAT_TX_EMPTY_BIT = 2;  // transmit FIFO holds nothing
  localparam int STAT_RX_EMPTY_BIT = 3;  // receive FIFO holds nothing

endpackage

//--- rtl/uart_fifo.sv
module uart_fifo #(
  parameter int  DEPTH = 4,            // number of entries
  parameter type T     = logic [7:0]   // payload carried per entry
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_push,   // ignored while full
  input  T     i_wdata,
  input  logic i_pop,    // ignored while empty
  output T     o_rdata,  // head entry, valid whenever o_empty is low
  output logic o_empty,
  output logic o_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;   // occupancy, 0 to DEPTH
  logic          do_push;
  logic          do_pop;

  // wrap explicitly so DEPTH need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    logic [AW-1:0] nxt;
    nxt = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign o_empty = (count == '0);
  assign o_full  = (count == CW'(DEPTH));
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;
  assign o_rdata = mem[rd_ptr];  // a push shows up here on the following cycle

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leave occupancy alone
      endcase
    end
  end

endmodule

//--- rtl/uart_ctrl_regs.sv
module uart_ctrl_regs (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            i_we,             // host write strobe
  input  logic [1:0]      i_addr,           // register select, shared by read and write
  input  uart_pkg::byte_t i_wdata,
  output uart_pkg::byte_t o_rdata,          // combinational read data
  input  logic            i_tx_idle,
  input  logic            i_tx_empty,
  input  logic            i_rx_empty,
  input  logic            i_ferr_pulse,     // one cycle per received word with a bad stop bit
  input  logic            i_overrun_pulse,  // one cycle per word dropped at a full rx FIFO
  output logic            o_tx_en,
  output logic            o_loopback
);

  logic            tx_en_q;     // control bit, gates tx FIFO drain
  logic            loop_q;      // control bit, selects the receiver input
  logic            overrun_q;   // sticky until the status register is written
  uart_pkg::byte_t ferr_cnt;    // saturates at all ones
  logic            wr_ctrl;
  logic            wr_status;
  logic            wr_ferr;

  assign wr_ctrl   = i_we && (i_addr == uart_pkg::REG_CTRL);
  assign wr_status = i_we && (i_addr == uart_pkg::REG_STATUS);  // any write clears overrun
  assign wr_ferr   = i_we && (i_addr == uart_pkg::REG_FERR);    // any write clears the count

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_en_q   <= 1'b0;
      loop_q    <= 1'b0;
      overrun_q <= 1'b0;
      ferr_cnt  <= '0;
    end else begin
      if (wr_ctrl) begin
        tx_en_q <= i_wdata[uart_pkg::CTRL_TX_EN_BIT];
        loop_q  <= i_wdata[uart_pkg::CTRL_LOOP_BIT];
      end
      if (i_overrun_pulse) begin
        overrun_q <= 1'b1;  // a new drop wins over a clear in the same cycle
      end else if (wr_status) begin
        overrun_q <= 1'b0;
      end
      if (wr_ferr) begin
        ferr_cnt <= '0;
      end else if (i_ferr_pulse && (ferr_cnt != '1)) begin
        ferr_cnt <= ferr_cnt + 1'b1;  // holds at 8'hff once saturated
      end
    end
  end

  always_comb begin
    o_rdata = '0;  // unmapped address reads as zero
    case (i_addr)
      uart_pkg::REG_CTRL: begin
        o_rdata[uart_pkg::CTRL_TX_EN_BIT] = tx_en_q;
        o_rdata[uart_pkg::CTRL_LOOP_BIT]  = loop_q;
      end
      uart_pkg::REG_STATUS: begin
        o_rdata[uart_pkg::STAT_TX_IDLE_BIT]  = i_tx_idle;
        o_rdata[uart_pkg::STAT_OVERRUN_BIT]  = overrun_q;
        o_rdata[uart_pkg::STAT_TX_EMPTY_BIT] = i_tx_empty;
        o_rdata[uart_pkg::STAT_RX_EMPTY_BIT] = i_rx_empty;
      end
      uart_pkg::REG_FERR: o_rdata = ferr_cnt;
      default: o_rdata = '0;
    endcase
  end

  assign o_tx_en    = tx_en_q;
  assign o_loopback = loop_q;

endmodule

//--- rtl/uart_tx.sv
module uart_tx #(
  parameter int CYCLES_PER_BIT = 4  // clocks per serial bit
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::byte_t i_data,    // byte taken when i_req and o_cts are both high
  input  logic            i_req,
  output logic            o_serial,  // idles high
  output logic            o_cts,     // ready to accept the next byte
  output logic            o_idle     // nothing left to shift, stop bits included
);

  localparam int TIMER_W  = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;
  localparam int CURSOR_W = $clog2(uart_pkg::FRAME_BITS);

  localparam logic [TIMER_W-1:0]  TIMER_MAX   = TIMER_W'(CYCLES_PER_BIT - 1);
  localparam logic [CURSOR_W-1:0] CURSOR_MAX  = CURSOR_W'(uart_pkg::FRAME_BITS - 1);
  localparam logic [CURSOR_W-1:0] CURSOR_STOP = CURSOR_W'(uart_pkg::EXTRA_STOP_BITS);

  logic [TIMER_W-1:0]  cycle;   // clocks left in the current bit
  logic [CURSOR_W-1:0] cursor;  // bits left in the frame, counts down to zero
  logic [8:0]          buffer;  // start bit plus data, lsb is on the line
  logic                accept;

  // the cursor reaches CURSOR_STOP during the real stop bit, below it are only the extra stops
  // so cts comes up once the ten real bits have gone and a queued byte cuts the extra stops
  assign o_cts    = (cursor < CURSOR_STOP);
  assign o_idle   = (cursor == '0) && (cycle == '0);
  assign o_serial = buffer[0];
  assign accept   = i_req && o_cts;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle  <= '0;
      cursor <= '0;
      buffer <= '1;  // line must sit at mark level out of reset
    end else if (accept) begin
      cycle  <= TIMER_MAX;
      cursor <= CURSOR_MAX;
      buffer <= {i_data, 1'b0};  // start bit goes out on the next clock
    end else if (cycle != '0) begin
      cycle <= cycle - 1'b1;  // hold the current bit
    end else if (cursor != '0) begin
      cycle  <= TIMER_MAX;
      cursor <= cursor - 1'b1;
      buffer <= {1'b1, buffer[8:1]};  // shift in ones so stop bits follow the data
    end
  end

endmodule

//--- rtl/uart_rx.sv
module uart_rx #(
  parameter int CYCLES_PER_BIT = 4  // clocks per serial bit, same as the transmitter
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_serial,  // asynchronous line, idles high
  output logic               o_valid,   // one cycle per completed frame
  output uart_pkg::rx_word_t o_word     // only meaningful while o_valid is high
);

  localparam int HALF    = (CYCLES_PER_BIT > 1) ? CYCLES_PER_BIT / 2 : 1;
  localparam int TIMER_W = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;

  localparam logic [TIMER_W-1:0] TIMER_MAX = TIMER_W'(CYCLES_PER_BIT - 1);
  localparam logic [TIMER_W-1:0] HALF_MAX  = TIMER_W'(HALF - 1);

  typedef enum logic [1:0] {
    RX_IDLE,   // waiting for a high to low transition
    RX_START,  // confirming the start bit at mid-bit
    RX_DATA,   // sampling the eight data bits
    RX_STOP    // sampling the stop bit
  } rx_state_t;

  rx_state_t           state;
  logic [2:0]          sync;     // two sync flops plus one history flop for edge detect
  logic                rxd;      // synchronized line level
  logic                fall;
  logic [TIMER_W-1:0]  timer;    // clocks until the next sample point
  logic [2:0]          bit_idx;  // data bit being sampled
  uart_pkg::byte_t     shift;    // data assembles here lsb first
  logic                sample;

  assign rxd    = sync[1];
  assign fall   = sync[2] && !sync[1];
  assign sample = (timer == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync    <= '1;  // looks like an idle line, no false edge out of reset
      state   <= RX_IDLE;
      timer   <= '0;
      bit_idx <= '0;
      o_valid <= 1'b0;
    end else begin
      sync    <= {sync[1:0], i_serial};
      o_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state <= RX_START;
            timer <= HALF_MAX;  // lands the next sample in the middle of the start bit
          end
        end
        RX_START: begin
          if (!sample) begin
            timer <= timer - 1'b1;
          end else if (rxd) begin
            state <= RX_IDLE;  // line went back high, treat it as a glitch
          end else begin
            state   <= RX_DATA;
            timer   <= TIMER_MAX;
            bit_idx <= '0;
          end
        end
        RX_DATA: begin
          if (!sample) begin
            timer <= timer - 1'b1;
          end else begin
            timer   <= TIMER_MAX;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (!sample) begin
            timer <= timer - 1'b1;
          end else begin
            o_valid <= 1'b1;  // mid stop bit, so edge detect is rearmed before the next start
            state   <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == RX_DATA) && sample) begin
      shift <= {rxd, shift[7:1]};  // first bit ends up in bit 0
    end
    if ((state == RX_STOP) && sample) begin
      o_word.data <= shift;
      o_word.ferr <= !rxd;  // a low stop bit is a framing error
    end
  end

endmodule

//--- rtl/uart_top.sv
module uart_top #(
  parameter int CYCLES_PER_BIT = 4,  // serial bit time in clocks
  parameter int TX_DEPTH       = 4,  // also the number of tx credits the host starts with
  parameter int RX_DEPTH       = 4   // also the ceiling of the rx credit counter
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            i_tx_valid,   // host spends one tx credit per pulse
  input  uart_pkg::byte_t i_tx_data,
  output logic            o_tx_credit,  // one tx credit back per byte taken by the serializer
  input  logic            i_rx_credit,  // host grants one rx credit per pulse
  output logic            o_rx_valid,   // one received word, spends one rx credit
  output uart_pkg::byte_t o_rx_data,
  output logic            o_rx_err,     // framing error of the word on o_rx_data
  input  logic            i_cfg_we,
  input  logic [1:0]      i_cfg_addr,
  input  uart_pkg::byte_t i_cfg_wdata,
  output uart_pkg::byte_t o_cfg_rdata,
  output logic            o_serial_tx,
  input  logic            i_serial_rx
);

  localparam int RX_CW = $clog2(RX_DEPTH + 1);

  uart_pkg::byte_t    tx_head;        // byte waiting at the tx FIFO head
  logic               tx_empty;
  logic               tx_req;
  logic               tx_cts;
  logic               tx_accept;      // serializer takes the head byte, FIFO pops
  logic               tx_idle;
  logic               serial_tx;
  logic               rx_in;          // receiver input after the loopback mux
  logic               rx_valid;
  uart_pkg::rx_word_t rx_word;
  uart_pkg::rx_word_t rx_head;
  logic               rx_empty;
  logic               rx_full;
  logic               rx_pop;
  logic [RX_CW-1:0]   rx_credits;     // granted and not yet used
  logic               tx_en;
  logic               loopback;
  logic               overrun_pulse;
  logic               ferr_pulse;

  assign tx_req        = !tx_empty && tx_en;  // tx_en low parks bytes and their credits
  assign tx_accept     = tx_req && tx_cts;
  assign o_serial_tx   = serial_tx;
  assign rx_in         = loopback ? serial_tx : i_serial_rx;
  assign overrun_pulse = rx_valid && rx_full;  // FIFO drops this word on its own
  assign ferr_pulse    = rx_valid && rx_word.ferr;
  assign rx_pop        = !rx_empty && (rx_credits != '0);

  uart_ctrl_regs u_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_we            (i_cfg_we),
    .i_addr          (i_cfg_addr),
    .i_wdata         (i_cfg_wdata),
    .o_rdata         (o_cfg_rdata),
    .i_tx_idle       (tx_idle),
    .i_tx_empty      (tx_empty),
    .i_rx_empty      (rx_empty),
    .i_ferr_pulse    (ferr_pulse),
    .i_overrun_pulse (overrun_pulse),
    .o_tx_en         (tx_en),
    .o_loopback      (loopback)
  );

  uart_fifo #(.DEPTH(TX_DEPTH), .T(uart_pkg::byte_t)) u_tx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_push  (i_tx_valid),  // credits keep the host from pushing into a full FIFO
    .i_wdata (i_tx_data),
    .i_pop   (tx_accept),
    .o_rdata (tx_head),
    .o_empty (tx_empty),
    .o_full  ()
  );

  uart_tx #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_data   (tx_head),
    .i_req    (tx_req),
    .o_serial (serial_tx),
    .o_cts    (tx_cts),
    .o_idle   (tx_idle)
  );

  uart_rx #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_serial (rx_in),
    .o_valid  (rx_valid),
    .o_word   (rx_word)
  );

  uart_fifo #(.DEPTH(RX_DEPTH), .T(uart_pkg::rx_word_t)) u_rx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_push  (rx_valid),
    .i_wdata (rx_word),
    .i_pop   (rx_pop),
    .o_rdata (rx_head),
    .o_empty (rx_empty),
    .o_full  (rx_full)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_tx_credit <= 1'b0;
      rx_credits  <= '0;
      o_rx_valid  <= 1'b0;
      o_rx_err    <= 1'b0;
    end else begin
      o_tx_credit <= tx_accept;  // returns the credit one cycle after the pop
      o_rx_valid  <= rx_pop;
      o_rx_err    <= rx_pop && rx_head.ferr;  // qualified so it never lingers
      if (i_rx_credit && rx_pop) begin
        rx_credits <= rx_credits;  // grant and use cancel out
      end else if (i_rx_credit && (rx_credits != RX_CW'(RX_DEPTH))) begin
        rx_credits <= rx_credits + 1'b1;  // grants beyond RX_DEPTH are lost
      end else if (rx_pop) begin
        rx_credits <= rx_credits - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_pop) begin
      o_rx_data <= rx_head.data;
    end
  end

endmodule

//--- verif/uart_assert.sv
module uart_assert #(
  parameter int CYCLES_PER_BIT = 4,  // clocks per serial bit, as in the DUT
  parameter int TX_DEPTH       = 4   // tx credits the host starts with
) (
  input logic            clk,
  input logic            rst_n,
  input logic            i_tx_valid,   // host push into the tx FIFO
  input uart_pkg::byte_t i_tx_data,
  input logic            i_tx_credit,  // credit returned by the DUT
  input logic            i_rx_grant,   // credit granted by the host
  input logic            i_rx_valid,
  input uart_pkg::byte_t i_rx_data,
  input logic            i_rx_err,
  input logic            i_serial_tx,
  input logic            i_tx_accept,  // serializer takes the FIFO head
  input logic            i_tx_en,
  input logic            i_tx_idle,
  input logic            i_loopback
);

  // the next byte is taken only after the ten real bits have gone, so at least one clock
  // of extra stop separates the stop bit from the next start bit
  localparam int MIN_START_GAP =
    (uart_pkg::FRAME_BITS - uart_pkg::EXTRA_STOP_BITS) * CYCLES_PER_BIT + 1;

  uart_pkg::byte_t sent_q[$];       // host bytes not yet seen at the receive port, oldest first
  uart_pkg::byte_t exp_byte;        // head of sent_q as of the last edge
  logic            exp_valid;
  int              tx_held;         // credits the host owns right now
  int              rx_open;         // granted minus delivered
  int              since_start;     // clocks since the serializer last took a byte
  int              error_count = 0; // failed assertions so far

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sent_q.delete();
      exp_valid   <= 1'b0;
      exp_byte    <= '0;
      tx_held     <= TX_DEPTH;
      rx_open     <= 0;
      since_start <= MIN_START_GAP;  // first frame after reset has no predecessor
    end else begin
      if (i_rx_valid && !i_rx_err && (sent_q.size() != 0)) begin
        void'(sent_q.pop_front());  // a clean word retires the oldest byte
      end
      if (i_tx_valid) begin
        sent_q.push_back(i_tx_data);
      end
      exp_valid   <= (sent_q.size() != 0);
      exp_byte    <= (sent_q.size() != 0) ? sent_q[0] : '0;
      tx_held     <= tx_held - int'(i_tx_valid) + int'(i_tx_credit);
      rx_open     <= rx_open + int'(i_rx_grant) - int'(i_rx_valid);
      since_start <= i_tx_accept ? 1 : since_start + int'(since_start < MIN_START_GAP);
    end
  end

  task automatic count_failure();
    error_count++;
  endtask

  tx_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
    (tx_held <= TX_DEPTH) && (!i_tx_valid || (tx_held > 0)))
    else begin $error("tx credit count out of range"); count_failure(); end
  credit_per_accept: assert property (@(posedge clk) disable iff (!rst_n)
    i_tx_accept |=> i_tx_credit) else begin $error("credit missing"); count_failure(); end
  no_spare_credit: assert property (@(posedge clk) disable iff (!rst_n)
    !i_tx_accept |=> !i_tx_credit) else begin $error("spare credit"); count_failure(); end
  disabled_line_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (!i_tx_en && i_tx_idle) |=> (i_tx_idle && i_serial_tx))
    else begin $error("transmitter started while disabled"); count_failure(); end
  rx_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    i_rx_valid |-> rx_open > 0) else begin $error("rx without credit"); count_failure(); end
  rx_data_order: assert property (@(posedge clk) disable iff (!rst_n)
    (i_rx_valid && !i_rx_err) |-> (exp_valid && (i_rx_data == exp_byte)))
    else begin $error("rx word out of order"); count_failure(); end
  loopback_clean: assert property (@(posedge clk) disable iff (!rst_n)
    (i_rx_valid && i_loopback) |-> !i_rx_err) else begin $error("ferr"); count_failure(); end
  frame_gap: assert property (@(posedge clk) disable iff (!rst_n)
    i_tx_accept |-> ((since_start >= MIN_START_GAP) && i_serial_tx))
    else begin $error("frames too close"); count_failure(); end

endmodule

//--- verif/uart_tb.sv
module uart_tb;

  localparam int CPB            = 4;  // clocks per serial bit
  localparam int TX_DEPTH       = 4;
  localparam int RX_DEPTH       = 4;
  localparam int TIMEOUT_CYCLES = 4000;  // 6 tests x 8 bytes x 17 bits x 4 clocks, plus margin
  localparam int WAIT_CYCLES    = 8 * uart_pkg::FRAME_BITS * CPB;  // bound on any single wait

  localparam uart_pkg::byte_t CTRL_TX_LOOP = uart_pkg::byte_t'(
    (1 << uart_pkg::CTRL_TX_EN_BIT) | (1 << uart_pkg::CTRL_LOOP_BIT));
  localparam uart_pkg::byte_t CTRL_LOOP = uart_pkg::byte_t'(1 << uart_pkg::CTRL_LOOP_BIT);
  localparam uart_pkg::byte_t CTRL_TX   = uart_pkg::byte_t'(1 << uart_pkg::CTRL_TX_EN_BIT);
  // idle transmitter with both FIFOs empty and no overrun
  localparam uart_pkg::byte_t STATUS_AT_RESET = uart_pkg::byte_t'(
    (1 << uart_pkg::STAT_TX_IDLE_BIT) | (1 << uart_pkg::STAT_TX_EMPTY_BIT) |
    (1 << uart_pkg::STAT_RX_EMPTY_BIT));

  logic            clk = 1'b0;
  logic            rst_n;
  logic            i_tx_valid;
  uart_pkg::byte_t i_tx_data;
  logic            o_tx_credit;
  logic            i_rx_credit = 1'b0;  // driven only by the grant process below
  logic            o_rx_valid;
  uart_pkg::byte_t o_rx_data;
  logic            o_rx_err;
  logic            i_cfg_we;
  logic [1:0]      i_cfg_addr;
  uart_pkg::byte_t i_cfg_wdata;
  uart_pkg::byte_t o_cfg_rdata;
  logic            o_serial_tx;
  logic            i_serial_rx;

  int              errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              errors_at_start = 0;
  int              cycles = 0;
  int              tx_sent = 0;     // pushes, each spends a credit
  int              tx_back = 0;     // credits returned by the DUT
  int              rx_target = 0;   // words the host is willing to take in total
  int              rx_granted = 0;
  int              rx_seen = 0;
  uart_pkg::byte_t last_rx_data;
  logic            last_rx_err;

  uart_top #(
    .CYCLES_PER_BIT (CPB),
    .TX_DEPTH       (TX_DEPTH),
    .RX_DEPTH       (RX_DEPTH)
  ) UUT (.*);

  bind uart_top uart_assert #(
    .CYCLES_PER_BIT (CYCLES_PER_BIT),
    .TX_DEPTH       (TX_DEPTH)
  ) u_assert (
    .clk (clk), .rst_n (rst_n), .i_tx_valid (i_tx_valid), .i_tx_data (i_tx_data),
    .i_tx_credit (o_tx_credit), .i_rx_grant (i_rx_credit), .i_rx_valid (o_rx_valid),
    .i_rx_data (o_rx_data), .i_rx_err (o_rx_err), .i_serial_tx (o_serial_tx),
    .i_tx_accept (tx_accept), .i_tx_en (tx_en), .i_tx_idle (tx_idle), .i_loopback (loopback)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped, still busy after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (rst_n && o_tx_credit) begin
      tx_back++;
    end
    if (rst_n && o_rx_valid) begin
      rx_seen++;
      last_rx_data = o_rx_data;
      last_rx_err  = o_rx_err;
    end
  end

  // hands out rx credits one per cycle while never owing more than RX_DEPTH words
  always @(negedge clk) begin
    i_rx_credit = 1'b0;
    if (rst_n && (rx_granted < rx_target) && (rx_granted - rx_seen < RX_DEPTH)) begin
      i_rx_credit = 1'b1;
      rx_granted++;
    end
  end

  function automatic int tx_credits_held();
    return TX_DEPTH - tx_sent + tx_back;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input uart_pkg::byte_t data);
    @(negedge clk);
    i_cfg_we    = 1'b1;
    i_cfg_addr  = addr;
    i_cfg_wdata = data;
    @(negedge clk);
    i_cfg_we    = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] addr, output uart_pkg::byte_t data);
    @(negedge clk);
    i_cfg_addr = addr;
    @(posedge clk);
    data = o_cfg_rdata;  // combinational read, settled since the falling edge
  endtask

  task automatic send_byte(input uart_pkg::byte_t data);
    int waited;
    waited = 0;
    while ((tx_credits_held() == 0) && (waited < WAIT_CYCLES)) begin
      @(negedge clk);
      waited++;
    end
    if (tx_credits_held() == 0) begin
      $display("no transmit credit came back within %0d cycles", WAIT_CYCLES);
      errors++;
    end else begin
      @(negedge clk);
      i_tx_valid = 1'b1;
      i_tx_data  = data;
      tx_sent++;
      @(negedge clk);
      i_tx_valid = 1'b0;
    end
  endtask

  task automatic wait_rx_words(input int total);
    int waited;
    waited = 0;
    while ((rx_seen < total) && (waited < WAIT_CYCLES)) begin
      @(negedge clk);
      waited++;
    end
    if (rx_seen < total) begin
      $display("only %0d of %0d received words arrived in time", rx_seen, total);
      errors++;
    end
  endtask

  task automatic wait_tx_drained();
    uart_pkg::byte_t status;
    int              waited;
    waited = 0;
    read_reg(uart_pkg::REG_STATUS, status);
    while (!(status[uart_pkg::STAT_TX_IDLE_BIT] && status[uart_pkg::STAT_TX_EMPTY_BIT]) &&
           (waited < WAIT_CYCLES)) begin
      read_reg(uart_pkg::REG_STATUS, status);
      waited++;
    end
    if (!(status[uart_pkg::STAT_TX_IDLE_BIT] && status[uart_pkg::STAT_TX_EMPTY_BIT])) begin
      $display("transmitter did not drain within %0d polls", WAIT_CYCLES);
      errors++;
    end
  endtask

  // start, data lsb first, then a stop bit held low
  task automatic drive_bad_frame(input uart_pkg::byte_t data);
    logic [9:0] bits;
    bits = {1'b0, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      i_serial_rx = bits[i];
      repeat (CPB - 1) @(negedge clk);
    end
    @(negedge clk);
    i_serial_rx = 1'b1;
  endtask

  task automatic start_test();
    errors_at_start = errors + UUT.u_assert.error_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors + UUT.u_assert.error_count == errors_at_start) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  initial begin
    uart_pkg::byte_t value;
    uart_pkg::byte_t ferr_before;
    uart_pkg::byte_t bad_byte;
    void'($urandom(36900));
    rst_n       = 1'b0;
    i_tx_valid  = 1'b0;
    i_tx_data   = '0;
    i_cfg_we    = 1'b0;
    i_cfg_addr  = '0;
    i_cfg_wdata = '0;
    i_serial_rx = 1'b1;  // idle mark level
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test();
    read_reg(uart_pkg::REG_CTRL, value);
    check_value("ctrl", value, 8'h00);
    read_reg(uart_pkg::REG_STATUS, value);
    check_value("status", value, STATUS_AT_RESET);
    read_reg(uart_pkg::REG_FERR, value);
    check_value("ferr_count", value, 8'h00);
    end_test("register values after reset");

    start_test();
    write_reg(uart_pkg::REG_CTRL, CTRL_TX_LOOP);
    rx_target += 8;
    for (int i = 0; i < 8; i++) begin
      send_byte(uart_pkg::byte_t'($urandom));
    end
    wait_rx_words(rx_target);
    end_test("loopback data and order");

    start_test();
    write_reg(uart_pkg::REG_CTRL, CTRL_LOOP);  // bytes park in the tx FIFO
    for (int i = 0; i < TX_DEPTH; i++) begin
      send_byte(uart_pkg::byte_t'($urandom));
    end
    repeat (2 * uart_pkg::FRAME_BITS * CPB) @(negedge clk);
    if (tx_credits_held() != 0) begin
      $display("a transmit credit came back while the transmitter was disabled");
      errors++;
    end
    if (o_serial_tx !== 1'b1) begin
      $display("serial line left idle while the transmitter was disabled");
      errors++;
    end
    rx_target += TX_DEPTH;
    write_reg(uart_pkg::REG_CTRL, CTRL_TX_LOOP);
    wait_rx_words(rx_target);
    check_value("tx credits held", 8'(tx_credits_held()), 8'(TX_DEPTH));
    end_test("transmit credits and tx enable");

    start_test();
    for (int i = 0; i < RX_DEPTH; i++) begin
      send_byte(uart_pkg::byte_t'($urandom));
    end
    wait_tx_drained();
    if (rx_seen != rx_target) begin
      $display("a word was delivered without a receive credit");
      errors++;
    end
    read_reg(uart_pkg::REG_STATUS, value);
    check_value("status rx_empty", 8'(value[uart_pkg::STAT_RX_EMPTY_BIT]), 8'h00);
    check_value("status overrun", 8'(value[uart_pkg::STAT_OVERRUN_BIT]), 8'h00);
    rx_target += RX_DEPTH;  // now release the held words
    wait_rx_words(rx_target);
    end_test("receive credits withheld");

    start_test();
    rx_target += 4;
    for (int i = 0; i < 4; i++) begin
      send_byte(uart_pkg::byte_t'($urandom));
    end
    wait_rx_words(rx_target);
    end_test("frame gap between back-to-back bytes");

    start_test();
    wait_tx_drained();  // line quiet before the receiver input is switched
    write_reg(uart_pkg::REG_CTRL, CTRL_TX);
    read_reg(uart_pkg::REG_FERR, ferr_before);
    bad_byte = uart_pkg::byte_t'($urandom);
    rx_target += 1;
    drive_bad_frame(bad_byte);
    wait_rx_words(rx_target);
    check_value("o_rx_err", 8'(last_rx_err), 8'h01);
    check_value("o_rx_data", last_rx_data, bad_byte);
    read_reg(uart_pkg::REG_FERR, value);
    check_value("ferr_count", value, uart_pkg::byte_t'(ferr_before + 1));
    write_reg(uart_pkg::REG_FERR, 8'h00);
    read_reg(uart_pkg::REG_FERR, value);
    check_value("ferr_count after clear", value, 8'h00);
    end_test("framing error and counter clear");

    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if ((tests_failed == 0) && (errors == 0) && (UUT.u_assert.error_count == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_ctrl_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verif/uart_assert.sv
verif/uart_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f project.f -o uart_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/uart_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
